/* Makefile */
VERILATOR ?= verilator
TOP       ?= cmp_rs_tb
FILELIST  ?= cmp_rs_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the testbench and look for the pass message"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* bench/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset held for 5 rising edges, released just after the last one
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule : clk_gen

/* bench/cmp_rs_tb.sv */
`timescale 1ns/100ps

module cmp_rs_tb;

    import tomasulo_pkg::*;

    // Source modes of a table row
    localparam logic [1:0] KNOWN = 2'd0;
    localparam logic [1:0] ROB   = 2'd1;
    localparam logic [1:0] CDB   = 2'd2;

    typedef struct packed {
        cmp_op_t    op;
        logic [1:0] m1;
        logic [1:0] m2;
        rv32i_word  a;
        rv32i_word  b;
        logic       taken;
    } row_t;

    logic                        clk;
    logic                        rst_n;
    logic                        flush;
    logic                        load;
    logic                        full;
    cmp_dispatch_t               dispatch;
    rv32i_word [ROB_ENTRIES-1:0] rob_vals;
    logic [ROB_ENTRIES-1:0]      rob_ready;
    cdb_t                        cdb;
    cdb_entry_t                  cdb_out;

    // Scoreboard holds at most one outstanding result per tag
    logic [ROB_ENTRIES-1:0] sb_busy;
    logic [ROB_ENTRIES-1:0] sb_taken;
    int                     got_cyc [ROB_ENTRIES];
    rob_tag_t               got_q [$];
    row_t                   rows [13];
    cmp_op_t                ops [6] = '{CMP_BEQ, CMP_BNE, CMP_BLT, CMP_BGE, CMP_BLTU, CMP_BGEU};
    rob_tag_t               order [4] = '{3'd4, 3'd5, 3'd6, 3'd0};
    int                     cyc = 0;
    int                     errors = 0;
    int                     checks = 0;

    clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    cmp_rs_top DUT (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .flush_i     (flush),
        .load_i      (load),
        .dispatch_i  (dispatch),
        .rob_vals_i  (rob_vals),
        .rob_ready_i (rob_ready),
        .cdb_i       (cdb),
        .cdb_cmp_o   (cdb_out),
        .full_o      (full)
    );

    task automatic check_eq(input logic [31:0] act, input logic [31:0] exp, input string msg);
        checks++;
        if (act !== exp) begin
            $display("Fail at %0t: %s, got %0h, expected %0h", $time, msg, act, exp);
            errors++;
        end
    endtask

    // Signed order is the unsigned order with both sign bits flipped
    function automatic logic branch_taken(cmp_op_t op, rv32i_word a, rv32i_word b);
        rv32i_word fa;
        rv32i_word fb;
        fa = a ^ 32'h8000_0000;
        fb = b ^ 32'h8000_0000;
        case (op)
            CMP_BEQ:  return a == b;
            CMP_BNE:  return a != b;
            CMP_BLT:  return fa < fb;
            CMP_BGE:  return !(fa < fb);
            CMP_BLTU: return a < b;
            default:  return !(a < b);
        endcase
    endfunction

    // One clock; inputs change and outputs are sampled 1 ns after the edge
    task automatic step();
        rob_tag_t t;
        @(posedge clk);
        #1;
        cyc++;
        t = cdb_out.tag;
        if (cdb_out.valid && !sb_busy[t]) begin
            $display("Unexpected result for tag %0d at %0t", t, $time);
            errors++;
        end else if (cdb_out.valid) begin
            check_eq(cdb_out.value, {31'b0, sb_taken[t]}, $sformatf("taken bit of tag %0d", t));
            sb_busy[t] = 1'b0;
            got_cyc[t] = cyc;
            got_q.push_back(t);
        end
    endtask

    task automatic set_src(input logic [1:0] mode, input rob_tag_t tag, input rv32i_word v,
                           output src_t s);
        s.pending      = (mode != KNOWN);
        s.tag          = tag;
        s.value        = (mode == KNOWN) ? v : ~v;
        rob_vals[tag]  = v;
        rob_ready[tag] = (mode == ROB);
    endtask

    task automatic dispatch_op(input cmp_op_t op, input src_t s1, input src_t s2,
                               input rob_tag_t dest, input logic taken);
        dispatch.op      = op;
        dispatch.src1    = s1;
        dispatch.src2    = s2;
        dispatch.rob_idx = dest;
        load             = 1'b1;
        sb_busy[dest]    = 1'b1;
        sb_taken[dest]   = taken;
        step();
        load = 1'b0;
    endtask

    task automatic broadcast(input logic v0, input rob_tag_t t0, input rv32i_word d0,
                             input logic v1, input rob_tag_t t1, input rv32i_word d1);
        cdb[0] = {v0, t0, d0};
        cdb[1] = {v1, t1, d1};
        step();
        cdb = '0;
    endtask

    task automatic wait_results(input logic [ROB_ENTRIES-1:0] mask, input int limit);
        int n;
        n = 0;
        while ((sb_busy & mask) != '0 && n < limit) begin
            step();
            n++;
        end
        if ((sb_busy & mask) != '0) begin
            $display("Timeout at %0t, no result for tags %b", $time, sb_busy & mask);
            errors++;
            sb_busy = sb_busy & ~mask;
        end
    endtask

    task automatic run_row(input row_t r, input rob_tag_t dest);
        src_t                   s1;
        src_t                   s2;
        int                     ref_cyc;
        logic [ROB_ENTRIES-1:0] mask;
        mask       = '0;
        mask[dest] = 1'b1;
        set_src(r.m1, 3'd6, r.a, s1);
        set_src(r.m2, 3'd7, r.b, s2);
        dispatch_op(r.op, s1, s2, dest, r.taken);
        ref_cyc = cyc;
        if (r.m1 == CDB || r.m2 == CDB) begin
            // Nothing may come out while an operand is still missing
            repeat (4) step();
            check_eq(32'(sb_busy[dest]), 32'd1, "no result before broadcast");
            broadcast(r.m1 == CDB, 3'd6, r.a, r.m2 == CDB, 3'd7, r.b);
            ref_cyc = cyc;
        end
        wait_results(mask, 10);
        check_eq(got_cyc[dest] - ref_cyc, 32'd2, "result latency");
    endtask

    task automatic report(input int num, input string name, input int base);
        $display("Test %0d (%s) done, %0d errors", num, name, errors - base);
    endtask

    initial begin
        int   n;
        int   base;
        int   wake_cyc;
        row_t r;
        src_t s1;
        src_t s2;
        void'($urandom(32'hb1d6_d193));
        flush     = 1'b0;
        load      = 1'b0;
        dispatch  = '0;
        rob_vals  = '0;
        rob_ready = '0;
        cdb       = '0;
        sb_busy   = '0;
        sb_taken  = '0;
        rows = '{
            '{CMP_BEQ,  KNOWN, KNOWN, 32'h0000_0005, 32'h0000_0005, 1'b1},
            '{CMP_BNE,  KNOWN, KNOWN, 32'h0000_0005, 32'h0000_0005, 1'b0},
            '{CMP_BLT,  KNOWN, KNOWN, 32'h8000_0000, 32'h7fff_ffff, 1'b1},
            '{CMP_BGE,  KNOWN, KNOWN, 32'h8000_0000, 32'h7fff_ffff, 1'b0},
            '{CMP_BLTU, KNOWN, KNOWN, 32'h8000_0000, 32'h7fff_ffff, 1'b0},
            '{CMP_BGEU, KNOWN, KNOWN, 32'hffff_ffff, 32'h0000_0000, 1'b1},
            '{CMP_BLTU, KNOWN, KNOWN, 32'h0000_0000, 32'hffff_ffff, 1'b1},
            '{CMP_BGE,  KNOWN, KNOWN, 32'h7fff_ffff, 32'h7fff_ffff, 1'b1},
            '{CMP_BLT,  ROB,   KNOWN, 32'hffff_ffff, 32'h0000_0001, 1'b1},
            '{CMP_BNE,  KNOWN, ROB,   32'h0000_0000, 32'h0000_0001, 1'b1},
            '{CMP_BEQ,  CDB,   KNOWN, 32'h0000_1234, 32'h0000_1234, 1'b1},
            '{CMP_BGEU, CDB,   CDB,   32'h0000_0001, 32'h0000_0002, 1'b0},
            '{CMP_BLT,  ROB,   CDB,   32'hffff_fffe, 32'hffff_ffff, 1'b1}
        };
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            errors++;
        end
        step();

        base = errors;
        check_eq(32'(full), 32'd0, "full after reset");
        check_eq(32'(cdb_out.valid), 32'd0, "result valid after reset");
        report(1, "reset state", base);

        base = errors;
        for (int i = 0; i < 8; i++) begin
            run_row(rows[i], rob_tag_t'(i % 6));
        end
        report(2, "known operands", base);

        base = errors;
        run_row(rows[8], 3'd0);
        run_row(rows[9], 3'd1);
        for (int i = 0; i < 3; i++) begin
            r.op    = ops[3'($urandom_range(5))];
            r.m1    = ROB;
            r.m2    = ROB;
            r.a     = $urandom();
            r.b     = $urandom();
            r.taken = branch_taken(r.op, r.a, r.b);
            run_row(r, rob_tag_t'(i + 2));
        end
        report(3, "ROB operands", base);

        base = errors;
        for (int i = 10; i < 13; i++) begin
            run_row(rows[i], rob_tag_t'(i % 6));
        end
        report(4, "CDB wakeup", base);

        // Slot 0 waits on tag 1, slots 1 to 3 wait on tag 2
        base = errors;
        set_src(CDB, 3'd1, 32'd7, s1);
        set_src(KNOWN, 3'd0, 32'd7, s2);
        dispatch_op(CMP_BEQ, s1, s2, 3'd3, 1'b1);
        set_src(CDB, 3'd2, 32'd7, s1);
        dispatch_op(CMP_BEQ, s1, s2, 3'd4, 1'b1);
        dispatch_op(CMP_BNE, s1, s2, 3'd5, 1'b0);
        dispatch_op(CMP_BLTU, s1, s2, 3'd6, 1'b0);
        check_eq(32'(full), 32'd1, "full after four loads");
        broadcast(1'b1, 3'd1, 32'd7, 1'b0, 3'd0, 32'd0);
        wait_results(8'b0000_1000, 10);
        // Refilled slot 0 is now the youngest entry
        dispatch_op(CMP_BGEU, s1, s2, 3'd0, 1'b1);
        check_eq(32'(full), 32'd1, "full after refill");
        n = got_q.size();
        broadcast(1'b1, 3'd2, 32'd7, 1'b0, 3'd0, 32'd0);
        wake_cyc = cyc;
        wait_results('1, 12);
        check_eq(got_q.size(), n + 4, "result count after wakeup");
        if (got_q.size() == n + 4) begin
            for (int k = 0; k < 4; k++) begin
                check_eq(32'(got_q[n + k]), 32'(order[k]), "issue order");
                check_eq(got_cyc[order[k]] - wake_cyc, k + 2, "latency after wakeup");
            end
        end
        check_eq(32'(full), 32'd0, "full after drain");
        report(5, "full and age order", base);

        // Two waiting entries plus one that issues in the flush cycle
        base = errors;
        set_src(CDB, 3'd1, 32'd9, s1);
        dispatch_op(CMP_BEQ, s1, s2, 3'd2, 1'b0);
        dispatch_op(CMP_BNE, s1, s2, 3'd3, 1'b1);
        set_src(KNOWN, 3'd1, 32'd7, s1);
        dispatch_op(CMP_BEQ, s1, s2, 3'd4, 1'b1);
        flush = 1'b1;
        step();
        flush   = 1'b0;
        sb_busy = '0;
        check_eq(32'(full), 32'd0, "full after flush");
        broadcast(1'b1, 3'd1, 32'd9, 1'b0, 3'd0, 32'd0);
        repeat (4) step();
        run_row(rows[1], 3'd5);
        report(6, "flush", base);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : cmp_rs_tb

/* cmp_rs/cmp_rs_ctrl.sv */
`timescale 1ns/100ps

module cmp_rs_ctrl (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  load_i,
    input  tomasulo_pkg::rs_slot_t ready_vec_i,
    output tomasulo_pkg::rs_slot_t alloc_o,
    output tomasulo_pkg::rs_slot_t issue_o,
    output logic                  issue_valid_o,
    output logic                  full_o
);

    import tomasulo_pkg::*;

    rs_slot_t busy_q;
    // older_q[i][j] set means entry i was allocated before entry j
    rs_slot_t older_q [CMP_RS_SIZE];

    rs_slot_t free_vec;
    rs_slot_t cand;
    rs_slot_t blocked;

    assign full_o   = &busy_q;
    assign free_vec = ~busy_q;

    // Lowest free slot; zero when the station is full
    assign alloc_o = load_i ? (free_vec & (~free_vec + 1'b1)) : '0;

    // Only busy slots may issue
    assign cand = ready_vec_i & busy_q;

    // A candidate is blocked when any older candidate exists
    always_comb begin
        blocked = '0;
        for (int i = 0; i < CMP_RS_SIZE; i++) begin
            for (int j = 0; j < CMP_RS_SIZE; j++) begin
                if (j != i && cand[j] && older_q[j][i]) begin
                    blocked[i] = 1'b1;
                end
            end
        end
    end

    assign issue_o       = cand & ~blocked;
    assign issue_valid_o = |issue_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
            for (int i = 0; i < CMP_RS_SIZE; i++) begin
                older_q[i] <= '0;
            end
        end else if (flush_i) begin
            busy_q <= '0;
        end else begin
            // Issue frees a slot at the same edge as an allocation may fill another
            busy_q <= (busy_q & ~issue_o) | alloc_o;

            // New entry becomes the youngest
            for (int k = 0; k < CMP_RS_SIZE; k++) begin
                if (alloc_o[k]) begin
                    for (int j = 0; j < CMP_RS_SIZE; j++) begin
                        older_q[k][j] <= 1'b0;
                        if (j != k) begin
                            older_q[j][k] <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule : cmp_rs_ctrl

/* cmp_rs/cmp_rs_entries.sv */
`timescale 1ns/100ps

module cmp_rs_entries (
    input  logic                                                   clk,
    input  logic                                                   rst_n_i,
    input  tomasulo_pkg::cmp_dispatch_t                            dispatch_i,
    input  tomasulo_pkg::rs_slot_t                                 alloc_i,
    input  tomasulo_pkg::rv32i_word [tomasulo_pkg::ROB_ENTRIES-1:0] rob_vals_i,
    input  logic [tomasulo_pkg::ROB_ENTRIES-1:0]                   rob_ready_i,
    input  tomasulo_pkg::cdb_t                                     cdb_i,
    input  tomasulo_pkg::rs_slot_t                                 issue_i,
    output tomasulo_pkg::rs_slot_t                                 ready_vec_o,
    output tomasulo_pkg::cmp_issue_t                               issue_data_o
);

    import tomasulo_pkg::*;

    rs_entry_t entries_q [CMP_RS_SIZE];
    rs_entry_t entries_d [CMP_RS_SIZE];

    // Fill a waiting operand from any CDB slot carrying its tag
    function automatic operand_t snoop(operand_t opnd, cdb_t cdb);
        operand_t res;
        res = opnd;
        for (int j = 0; j < NUM_CDB_ENTRIES; j++) begin
            if (!opnd.ready && cdb[j].valid && cdb[j].tag == opnd.tag) begin
                res.ready = 1'b1;
                res.value = cdb[j].value;
            end
        end
        return res;
    endfunction

    // Resolve a dispatched source, CDB first then ROB
    function automatic operand_t capture(src_t src, rv32i_word [ROB_ENTRIES-1:0] rob_vals,
                                         logic [ROB_ENTRIES-1:0] rob_ready, cdb_t cdb);
        operand_t res;
        res.ready = !src.pending;
        res.tag   = src.tag;
        res.value = src.value;
        res = snoop(res, cdb);
        if (!res.ready && rob_ready[src.tag]) begin
            res.ready = 1'b1;
            res.value = rob_vals[src.tag];
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < CMP_RS_SIZE; i++) begin
            entries_d[i] = entries_q[i];
            if (alloc_i[i]) begin
                entries_d[i].op   = dispatch_i.op;
                entries_d[i].dest = dispatch_i.rob_idx;
                entries_d[i].rs1  = capture(dispatch_i.src1, rob_vals_i, rob_ready_i, cdb_i);
                entries_d[i].rs2  = capture(dispatch_i.src2, rob_vals_i, rob_ready_i, cdb_i);
            end else begin
                entries_d[i].rs1 = snoop(entries_q[i].rs1, cdb_i);
                entries_d[i].rs2 = snoop(entries_q[i].rs2, cdb_i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < CMP_RS_SIZE; i++) begin
                entries_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < CMP_RS_SIZE; i++) begin
                entries_q[i] <= entries_d[i];
            end
        end
    end

    // Readiness comes from stored state only, so a capture issues one edge later
    always_comb begin
        for (int i = 0; i < CMP_RS_SIZE; i++) begin
            ready_vec_o[i] = entries_q[i].rs1.ready & entries_q[i].rs2.ready;
        end
    end

    // Issue select is one-hot
    always_comb begin
        issue_data_o = '0;
        for (int i = 0; i < CMP_RS_SIZE; i++) begin
            if (issue_i[i]) begin
                issue_data_o.op      = entries_q[i].op;
                issue_data_o.vj      = entries_q[i].rs1.value;
                issue_data_o.vk      = entries_q[i].rs2.value;
                issue_data_o.rob_idx = entries_q[i].dest;
            end
        end
    end

endmodule : cmp_rs_entries

/* cmp_rs_top.f */
common/tomasulo_pkg.sv
cmp_rs/cmp_rs_ctrl.sv
cmp_rs/cmp_rs_entries.sv
design/cmp_unit.sv
design/cmp_rs_top.sv
bench/clk_gen.sv
bench/cmp_rs_tb.sv

/* common/tomasulo_pkg.sv */
package tomasulo_pkg;

    // Sizes
    localparam int ROB_ENTRIES     = 8;
    localparam int CMP_RS_SIZE     = 4;
    localparam int NUM_CDB_ENTRIES = 2;

    typedef logic [31:0]                    rv32i_word;
    typedef logic [$clog2(ROB_ENTRIES)-1:0] rob_tag_t;
    typedef logic [CMP_RS_SIZE-1:0]         rs_slot_t;

    // Compare codes follow the branch funct3 field
    typedef logic [2:0] cmp_op_t;

    localparam cmp_op_t CMP_BEQ  = 3'b000;
    localparam cmp_op_t CMP_BNE  = 3'b001;
    localparam cmp_op_t CMP_BLT  = 3'b100;
    localparam cmp_op_t CMP_BGE  = 3'b101;
    localparam cmp_op_t CMP_BLTU = 3'b110;
    localparam cmp_op_t CMP_BGEU = 3'b111;

    // Source as sent by the decoder; value is only meaningful when not pending
    typedef struct packed {
        logic      pending;
        rob_tag_t  tag;
        rv32i_word value;
    } src_t;

    typedef struct packed {
        cmp_op_t  op;
        src_t     src1;
        src_t     src2;
        rob_tag_t rob_idx;
    } cmp_dispatch_t;

    typedef struct packed {
        logic      ready;
        rob_tag_t  tag;
        rv32i_word value;
    } operand_t;

    typedef struct packed {
        cmp_op_t  op;
        operand_t rs1;
        operand_t rs2;
        rob_tag_t dest;
    } rs_entry_t;

    typedef struct packed {
        cmp_op_t   op;
        rv32i_word vj;
        rv32i_word vk;
        rob_tag_t  rob_idx;
    } cmp_issue_t;

    typedef struct packed {
        logic      valid;
        rob_tag_t  tag;
        rv32i_word value;
    } cdb_entry_t;

    typedef cdb_entry_t [NUM_CDB_ENTRIES-1:0] cdb_t;

endpackage : tomasulo_pkg

/* design/cmp_rs_top.sv */
`timescale 1ns/100ps

module cmp_rs_top (
    input  logic                                                   clk,
    input  logic                                                   rst_n_i,
    input  logic                                                   flush_i,
    input  logic                                                   load_i,
    input  tomasulo_pkg::cmp_dispatch_t                            dispatch_i,
    input  tomasulo_pkg::rv32i_word [tomasulo_pkg::ROB_ENTRIES-1:0] rob_vals_i,
    input  logic [tomasulo_pkg::ROB_ENTRIES-1:0]                   rob_ready_i,
    input  tomasulo_pkg::cdb_t                                     cdb_i,
    output tomasulo_pkg::cdb_entry_t                               cdb_cmp_o,
    output logic                                                   full_o
);

    import tomasulo_pkg::*;

    rs_slot_t   alloc;
    rs_slot_t   issue;
    rs_slot_t   ready_vec;
    logic       issue_valid;
    cmp_issue_t issue_data;

    cmp_rs_ctrl u_ctrl (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .load_i        (load_i),
        .ready_vec_i   (ready_vec),
        .alloc_o       (alloc),
        .issue_o       (issue),
        .issue_valid_o (issue_valid),
        .full_o        (full_o)
    );

    cmp_rs_entries u_entries (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .dispatch_i   (dispatch_i),
        .alloc_i      (alloc),
        .rob_vals_i   (rob_vals_i),
        .rob_ready_i  (rob_ready_i),
        .cdb_i        (cdb_i),
        .issue_i      (issue),
        .ready_vec_o  (ready_vec),
        .issue_data_o (issue_data)
    );

    cmp_unit u_cmp (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid),
        .issue_data_i  (issue_data),
        .cdb_cmp_o     (cdb_cmp_o)
    );

endmodule : cmp_rs_top

/* design/cmp_unit.sv */
`timescale 1ns/100ps

module cmp_unit (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  logic                     issue_valid_i,
    input  tomasulo_pkg::cmp_issue_t issue_data_i,
    output tomasulo_pkg::cdb_entry_t cdb_cmp_o
);

    import tomasulo_pkg::*;

    logic       issue_valid_q;
    cmp_issue_t issue_q;
    logic       taken;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= issue_valid_i && !flush_i;
        end
    end

    // Operand latch
    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            issue_q <= issue_data_i;
        end
    end

    always_comb begin
        case (issue_q.op)
            CMP_BEQ:  taken = issue_q.vj == issue_q.vk;
            CMP_BNE:  taken = issue_q.vj != issue_q.vk;
            CMP_BLT:  taken = $signed(issue_q.vj) < $signed(issue_q.vk);
            CMP_BGE:  taken = $signed(issue_q.vj) >= $signed(issue_q.vk);
            CMP_BLTU: taken = issue_q.vj < issue_q.vk;
            CMP_BGEU: taken = issue_q.vj >= issue_q.vk;
            default:  taken = 1'b0;
        endcase
    end

    // Result slot stays valid for one cycle and a flush drops the pending result
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cdb_cmp_o <= '0;
        end else begin
            cdb_cmp_o.valid <= issue_valid_q && !flush_i;
            cdb_cmp_o.tag   <= issue_q.rob_idx;
            cdb_cmp_o.value <= rv32i_word'(taken);
        end
    end

endmodule : cmp_unit
